// ==== hdl/rv_isa_pkg.sv ====
// RV32I definitions shared by the load-store decode and the testbench
package rv_isa_pkg;

    // Architectural register and data word
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] word_t;

    // Raw instruction word as handed over by the issue stage
    localparam int ILEN = 32;
    typedef logic [ILEN-1:0] inst_t;

    // Instruction fields used by the LSU
    localparam int OPCODE_LEN = 7;
    localparam int FUNCT3_LEN = 3;
    typedef logic [OPCODE_LEN-1:0] opcode_t;
    typedef logic [FUNCT3_LEN-1:0] funct3_t;

    // Major opcodes
    localparam opcode_t OP_LOAD  = 7'b0000011;
    localparam opcode_t OP_STORE = 7'b0100011;

    // Width codes, shared between loads and stores where the encoding matches
    localparam funct3_t FUNCT3_LB_SB = 3'b000;
    localparam funct3_t FUNCT3_LH_SH = 3'b001;
    localparam funct3_t FUNCT3_LW_SW = 3'b010;
    // Unsigned variants exist for loads only
    localparam funct3_t FUNCT3_LBU   = 3'b100;
    localparam funct3_t FUNCT3_LHU   = 3'b101;

endpackage

// ==== hdl/lsu_pkg.sv ====
// LSU geometry, load buffer layout and access size encoding
package lsu_pkg;

    // Byte-addressed data memory of 256 bytes
    localparam int DMEM_ADDR_LEN = 8;
    localparam int WORD_BYTES = 4;
    localparam int BYTE_OFS_LEN = 2;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_WADDR_LEN = DMEM_ADDR_LEN - BYTE_OFS_LEN;

    // Cycles from read enable to read data
    localparam int DMEM_RD_LATENCY = 2;

    // Loads that may be outstanding at once
    localparam int LSB_DEPTH = 2;
    localparam int LSB_PTR_LEN = (LSB_DEPTH > 1) ? $clog2(LSB_DEPTH) : 1;
    localparam int LSB_CNT_LEN = $clog2(LSB_DEPTH + 1);

    typedef logic [DMEM_ADDR_LEN-1:0] byte_addr_t;
    typedef logic [DMEM_WADDR_LEN-1:0] word_addr_t;
    typedef logic [BYTE_OFS_LEN-1:0] byte_ofs_t;
    // One enable per byte lane
    typedef logic [WORD_BYTES-1:0] wmask_t;
    typedef logic [LSB_PTR_LEN-1:0] lsb_ptr_t;
    typedef logic [LSB_CNT_LEN-1:0] lsb_cnt_t;

    // Width of a memory access
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // Load buffer entry layout, MSB first
    // Byte offset, access size, signed flag
    localparam int LSB_SIGNED_BIT = 0;
    localparam int LSB_SIZE_LSB = 1;
    localparam int LSB_OFS_LSB = LSB_SIZE_LSB + $bits(access_size_e);
    localparam int LSB_ENTRY_LEN = LSB_OFS_LSB + BYTE_OFS_LEN;

    typedef logic [LSB_ENTRY_LEN-1:0] lsb_entry_t;

endpackage

// ==== hdl/lsu_ctrl.sv ====
`timescale 1ns/1ps

// Request decode, address generation and memory strobes
module lsu_ctrl
    import rv_isa_pkg::*;
    import lsu_pkg::*;
(
    input  logic       lsu_request_i,
    input  inst_t      inst_i,
    input  word_t      rs1_value_i,
    input  word_t      rs2_value_i,
    input  logic       lsb_full_i,
    output logic       misaligned_o,
    output logic       wr_en_o,
    output word_addr_t wr_addr_o,
    output wmask_t     wr_mask_o,
    output word_t      wr_data_o,
    output logic       rd_en_o,
    output word_addr_t rd_addr_o,
    output lsb_entry_t push_entry_o
);

    opcode_t      opcode;
    funct3_t      funct3;
    word_t        imm_i;
    word_t        imm_s;
    logic         is_load;
    logic         is_store;
    logic         mem_op;
    access_size_e size;
    logic         load_signed;
    byte_addr_t   eff_addr;
    byte_ofs_t    byte_ofs;
    logic         aligned;
    logic         accept;

    // Instruction fields
    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    // I-type and S-type immediates, sign extended
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};

    // Only the defined width codes count as memory ops
    assign is_load = (opcode == OP_LOAD) &&
        (funct3 inside {FUNCT3_LB_SB, FUNCT3_LH_SH, FUNCT3_LW_SW, FUNCT3_LBU, FUNCT3_LHU});
    assign is_store = (opcode == OP_STORE) &&
        (funct3 inside {FUNCT3_LB_SB, FUNCT3_LH_SH, FUNCT3_LW_SW});
    assign mem_op = is_load | is_store;

    // Access width and sign from funct3
    always_comb begin
        size = SIZE_WORD;
        load_signed = 1'b0;
        case (funct3)
            FUNCT3_LB_SB: begin
                size = SIZE_BYTE;
                load_signed = 1'b1;
            end
            FUNCT3_LH_SH: begin
                size = SIZE_HALF;
                load_signed = 1'b1;
            end
            FUNCT3_LBU: size = SIZE_BYTE;
            FUNCT3_LHU: size = SIZE_HALF;
            default: size = SIZE_WORD;
        endcase
    end

    // Effective byte address, upper bits beyond the memory are dropped
    assign eff_addr = byte_addr_t'(rs1_value_i + (is_store ? imm_s : imm_i));
    assign byte_ofs = eff_addr[BYTE_OFS_LEN-1:0];

    // Natural alignment per access size
    always_comb begin
        case (size)
            SIZE_BYTE: aligned = 1'b1;
            SIZE_HALF: aligned = ~byte_ofs[0];
            default:   aligned = (byte_ofs == '0);
        endcase
    end

    // Misaligned pulse does not depend on buffer space
    assign misaligned_o = lsu_request_i & mem_op & ~aligned;

    // A full buffer blocks stores as well as loads
    assign accept = lsu_request_i & mem_op & aligned & ~lsb_full_i;

    // Write port
    assign wr_en_o = accept & is_store;
    assign wr_addr_o = eff_addr[DMEM_ADDR_LEN-1:BYTE_OFS_LEN];

    // Lane enables follow size and offset
    always_comb begin
        case (size)
            SIZE_BYTE: wr_mask_o = wmask_t'(4'b0001) << byte_ofs;
            SIZE_HALF: wr_mask_o = wmask_t'(4'b0011) << byte_ofs;
            default:   wr_mask_o = '1;
        endcase
    end

    // Move rs2 up into the addressed lanes
    assign wr_data_o = rs2_value_i << {byte_ofs, 3'b000};

    // Read port, rd_en doubles as the buffer push
    assign rd_en_o = accept & is_load;
    assign rd_addr_o = eff_addr[DMEM_ADDR_LEN-1:BYTE_OFS_LEN];

    // Facts the aligner needs once the word comes back
    assign push_entry_o = {byte_ofs, size, load_signed};

endmodule

// ==== hdl/lsu_load_buffer.sv ====
`timescale 1ns/1ps

// In-order queue of outstanding load metadata
module lsu_load_buffer
    import lsu_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       push_i,
    input  lsb_entry_t push_entry_i,
    input  logic       pop_i,
    output lsb_entry_t head_entry_o,
    output logic       full_o
);

    lsb_entry_t entries [LSB_DEPTH];
    lsb_ptr_t   wr_ptr;
    lsb_ptr_t   rd_ptr;
    lsb_cnt_t   count;

    // Pointer increment with wrap for any depth
    function automatic lsb_ptr_t ptr_next(input lsb_ptr_t ptr);
        return (ptr == lsb_ptr_t'(LSB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Push and pop together leave the count unchanged
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            entries[wr_ptr] <= push_entry_i;
        end
    end

    // Head is visible without a read strobe
    assign head_entry_o = entries[rd_ptr];

    // Push is refused by the control block while this is high
    assign full_o = (count == lsb_cnt_t'(LSB_DEPTH));

endmodule

// ==== hdl/dmem.sv ====
`timescale 1ns/1ps

// Data memory, byte-masked write and pipelined read
module dmem
    import rv_isa_pkg::*;
    import lsu_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       wr_en_i,
    input  word_addr_t wr_addr_i,
    input  wmask_t     wr_mask_i,
    input  word_t      wr_data_i,
    input  logic       rd_en_i,
    input  word_addr_t rd_addr_i,
    output logic       rd_valid_o,
    output word_t      rd_data_o
);

    word_t mem [DMEM_WORDS];

    // One valid and one data register per read stage
    logic [DMEM_RD_LATENCY-1:0] rd_valid_q;
    word_t                      rd_data_q [DMEM_RD_LATENCY];

    // Write only the enabled byte lanes
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (wr_mask_i[b]) begin
                    mem[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

    // Valid shift chain
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_valid_q <= '0;
        end else begin
            rd_valid_q[0] <= rd_en_i;
            for (int s = 1; s < DMEM_RD_LATENCY; s++) begin
                rd_valid_q[s] <= rd_valid_q[s-1];
            end
        end
    end

    // Array read in the first stage, later stages just carry the word
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_q[0] <= mem[rd_addr_i];
        end
        for (int s = 1; s < DMEM_RD_LATENCY; s++) begin
            rd_data_q[s] <= rd_data_q[s-1];
        end
    end

    // Last stage
    assign rd_valid_o = rd_valid_q[DMEM_RD_LATENCY-1];
    assign rd_data_o = rd_data_q[DMEM_RD_LATENCY-1];

endmodule

// ==== hdl/lsu_load_align.sv ====
`timescale 1ns/1ps

// Narrow and extend the returned word for writeback
module lsu_load_align
    import rv_isa_pkg::*;
    import lsu_pkg::*;
(
    input  logic       rd_valid_i,
    input  word_t      rd_data_i,
    input  lsb_entry_t entry_i,
    output logic       writeback_valid_o,
    output word_t      writeback_value_o
);

    byte_ofs_t    byte_ofs;
    access_size_e size;
    logic         load_signed;
    word_t        shifted;
    word_t        value;

    // Unpack the head entry
    assign byte_ofs = entry_i[LSB_OFS_LSB +: BYTE_OFS_LEN];
    assign size = access_size_e'(entry_i[LSB_SIZE_LSB +: $bits(access_size_e)]);
    assign load_signed = entry_i[LSB_SIGNED_BIT];

    // Addressed lane moved down to bit 0
    assign shifted = rd_data_i >> {byte_ofs, 3'b000};

    // Sign or zero extension
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                value = {{24{load_signed & shifted[7]}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                value = {{16{load_signed & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                // Word loads are always at offset zero
                value = shifted;
            end
        endcase
    end

    // Writeback follows the memory valid directly
    assign writeback_valid_o = rd_valid_i;

    // Keep the value bus quiet between writebacks
    assign writeback_value_o = rd_valid_i ? value : '0;

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ps

// Load-store unit with its data memory
module lsu_top
    import rv_isa_pkg::*;
    import lsu_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  lsu_request_i,
    input  inst_t inst_i,
    input  word_t rs1_value_i,
    input  word_t rs2_value_i,
    output logic  busy_o,
    output logic  misaligned_o,
    output logic  writeback_valid_o,
    output word_t writeback_value_o
);

    // Control to memory
    logic       wr_en;
    word_addr_t wr_addr;
    wmask_t     wr_mask;
    word_t      wr_data;
    logic       rd_en;
    word_addr_t rd_addr;

    // Memory to aligner
    logic  rd_valid;
    word_t rd_data;

    // Load buffer
    lsb_entry_t push_entry;
    lsb_entry_t head_entry;
    logic       lsb_full;

    // Issuer must hold off while the buffer is full
    assign busy_o = lsb_full;

    lsu_ctrl ctrl0 (
        .lsu_request_i(lsu_request_i),
        .inst_i       (inst_i),
        .rs1_value_i  (rs1_value_i),
        .rs2_value_i  (rs2_value_i),
        .lsb_full_i   (lsb_full),
        .misaligned_o (misaligned_o),
        .wr_en_o      (wr_en),
        .wr_addr_o    (wr_addr),
        .wr_mask_o    (wr_mask),
        .wr_data_o    (wr_data),
        .rd_en_o      (rd_en),
        .rd_addr_o    (rd_addr),
        .push_entry_o (push_entry)
    );

    // Push on every issued read, pop on every returned word
    lsu_load_buffer lsb0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (rd_en),
        .push_entry_i(push_entry),
        .pop_i       (rd_valid),
        .head_entry_o(head_entry),
        .full_o      (lsb_full)
    );

    dmem dmem0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_mask_i (wr_mask),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_valid_o(rd_valid),
        .rd_data_o (rd_data)
    );

    // Head entry belongs to the word arriving this cycle
    lsu_load_align align0 (
        .rd_valid_i       (rd_valid),
        .rd_data_i        (rd_data),
        .entry_i          (head_entry),
        .writeback_valid_o(writeback_valid_o),
        .writeback_value_o(writeback_value_o)
    );

endmodule

// ==== tb/lsu_tb.sv ====
`timescale 1ns/1ps

// Table-driven testbench for the load-store unit
module lsu_tb
    import rv_isa_pkg::*;
    import lsu_pkg::*;
();

    typedef enum logic [1:0] {
        EXP_NONE,
        EXP_WB,
        EXP_MIS
    } exp_kind_e;

    // One stimulus row
    typedef struct packed {
        logic      req;
        inst_t     inst;
        word_t     rs1;
        word_t     rs2;
        exp_kind_e kind;
    } row_t;

    // Pending writeback with its accept cycle
    typedef struct packed {
        word_t       value;
        logic [15:0] row;
        logic [31:0] cycle;
    } wb_exp_t;

    logic  clk_i = 1'b0;
    logic  reset_i;
    logic  lsu_request_i;
    inst_t inst_i;
    word_t rs1_value_i;
    word_t rs2_value_i;
    logic  busy_o;
    logic  misaligned_o;
    logic  writeback_valid_o;
    word_t writeback_value_o;

    row_t        rows [$];
    wb_exp_t     expect_q [$];
    logic [7:0]  mem_model [256];
    logic [31:0] lfsr_state = 32'h3789;
    logic [31:0] cycle_count = '0;
    logic        table_ready = 1'b0;
    logic        busy_seen = 1'b0;
    int          pass_count = 0;
    int          fail_count = 0;

    lsu_top dut0 (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .lsu_request_i    (lsu_request_i),
        .inst_i           (inst_i),
        .rs1_value_i      (rs1_value_i),
        .rs2_value_i      (rs2_value_i),
        .busy_o           (busy_o),
        .misaligned_o     (misaligned_o),
        .writeback_valid_o(writeback_valid_o),
        .writeback_value_o(writeback_value_o)
    );

    // 100 ns clock
    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1'b1;
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic rand_word(output word_t w);
        for (int k = 0; k < 32; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[k] = lfsr_state[0];
        end
    endtask

    // I-type load with rs1 = x1 and rd = x5
    function automatic inst_t enc_load(input funct3_t f3, input logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd5, OP_LOAD};
    endfunction

    // S-type store with rs1 = x1 and rs2 = x2
    function automatic inst_t enc_store(input funct3_t f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OP_STORE};
    endfunction

    // Byte address per the RV32I immediate rules and cut to memory size
    function automatic byte_addr_t addr_of(input inst_t inst, input word_t rs1);
        logic [11:0] imm;
        word_t       sum;
        imm = (inst[6:0] == OP_STORE) ? {inst[31:25], inst[11:7]} : inst[31:20];
        sum = rs1 + {{20{imm[11]}}, imm};
        return sum[DMEM_ADDR_LEN-1:0];
    endfunction

    function automatic int bytes_of(input funct3_t f3);
        case (f3)
            FUNCT3_LB_SB, FUNCT3_LBU: return 1;
            FUNCT3_LH_SH, FUNCT3_LHU: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic string op_name(input inst_t inst);
        if (inst[6:0] == OP_LOAD) begin
            case (inst[14:12])
                FUNCT3_LB_SB: return "LB";
                FUNCT3_LH_SH: return "LH";
                FUNCT3_LW_SW: return "LW";
                FUNCT3_LBU:   return "LBU";
                FUNCT3_LHU:   return "LHU";
                default:      return "LD?";
            endcase
        end
        if (inst[6:0] == OP_STORE) begin
            return (inst[13:12] == 2'b00) ? "SB" : (inst[12] ? "SH" : "SW");
        end
        return "OTH";
    endfunction

    // Little-endian byte lanes where only the addressed ones change
    task automatic store_model(input byte_addr_t a, input funct3_t f3, input word_t data);
        for (int b = 0; b < bytes_of(f3); b++) begin
            mem_model[int'(a) + b] = data[8*b +: 8];
        end
    endtask

    // Gather bytes and sign extend for LB and LH
    function automatic word_t load_model(input byte_addr_t a, input funct3_t f3);
        word_t v;
        int    n;
        v = '0;
        n = bytes_of(f3);
        for (int b = 0; b < n; b++) begin
            v[8*b +: 8] = mem_model[int'(a) + b];
        end
        if ((f3 == FUNCT3_LB_SB || f3 == FUNCT3_LH_SH) && v[8*n-1]) begin
            for (int k = 8 * n; k < 32; k++) begin
                v[k] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what,
                              output logic ok);
        ok = (got === exp);
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("Fail at %0t: %s got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what,
                              output logic ok);
        ok = (got === exp);
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input logic req, input inst_t inst, input word_t rs1,
                           input word_t rs2, input exp_kind_e kind);
        rows.push_back('{req, inst, rs1, rs2, kind});
    endtask

    task automatic add_store(input funct3_t f3, input byte_addr_t a, input word_t data);
        add_row(1'b1, enc_store(f3, 12'd0), {24'd0, a}, data, EXP_NONE);
    endtask

    task automatic add_load(input funct3_t f3, input byte_addr_t a);
        add_row(1'b1, enc_load(f3, 12'd0), {24'd0, a}, '0, EXP_WB);
    endtask

    task automatic build_table();
        byte_addr_t word_addrs [4] = '{8'h00, 8'h04, 8'h10, 8'hFC};
        word_t      w;
        inst_t      ins;
        // Word round trips at scattered addresses
        foreach (word_addrs[i]) begin
            rand_word(w);
            add_store(FUNCT3_LW_SW, word_addrs[i], w);
        end
        foreach (word_addrs[i]) begin
            add_load(FUNCT3_LW_SW, word_addrs[i]);
        end
        // Negative immediates make the address wrap past the memory size
        rand_word(w);
        add_row(1'b1, enc_store(FUNCT3_LW_SW, 12'hFF8), 32'h0000_0008, w, EXP_NONE);
        add_row(1'b1, enc_load(FUNCT3_LW_SW, 12'hFFC), 32'h0000_0114, '0, EXP_WB);
        add_load(FUNCT3_LW_SW, 8'h00);
        // Byte and halfword lanes inside one word
        rand_word(w);
        add_store(FUNCT3_LW_SW, 8'h20, w);
        rand_word(w);
        add_store(FUNCT3_LB_SB, 8'h21, w);
        rand_word(w);
        add_store(FUNCT3_LH_SH, 8'h22, w);
        add_load(FUNCT3_LW_SW, 8'h20);
        rand_word(w);
        add_store(FUNCT3_LW_SW, 8'h24, w);
        rand_word(w);
        add_store(FUNCT3_LH_SH, 8'h24, w);
        rand_word(w);
        add_store(FUNCT3_LB_SB, 8'h27, w);
        add_load(FUNCT3_LW_SW, 8'h24);
        // Sign bits all set in one word and all clear in the next
        rand_word(w);
        add_store(FUNCT3_LW_SW, 8'h30, w | 32'h8080_8080);
        rand_word(w);
        add_store(FUNCT3_LW_SW, 8'h34, w & 32'h7F7F_7F7F);
        // Long back-to-back burst that fills the buffer
        for (int a = 0; a < 8; a++) begin
            add_load(FUNCT3_LB_SB, byte_addr_t'(48 + a));
            add_load(FUNCT3_LBU, byte_addr_t'(48 + a));
        end
        for (int a = 0; a < 8; a += 2) begin
            add_load(FUNCT3_LH_SH, byte_addr_t'(48 + a));
            add_load(FUNCT3_LHU, byte_addr_t'(48 + a));
        end
        // Misaligned accesses leave memory alone
        add_row(1'b1, enc_load(FUNCT3_LW_SW, 12'd2), 32'h20, '0, EXP_MIS);
        add_row(1'b1, enc_load(FUNCT3_LH_SH, 12'd1), 32'h20, '0, EXP_MIS);
        add_row(1'b1, enc_store(FUNCT3_LW_SW, 12'd2), 32'h24, 32'hDEAD_BEEF, EXP_MIS);
        add_row(1'b1, enc_store(FUNCT3_LH_SH, 12'd3), 32'h20, 32'hDEAD_BEEF, EXP_MIS);
        add_load(FUNCT3_LW_SW, 8'h20);
        add_load(FUNCT3_LW_SW, 8'h24);
        // Foreign opcodes, reserved width and an idle request
        ins = enc_store(FUNCT3_LW_SW, 12'd0);
        ins[6:0] = 7'b0110011;
        add_row(1'b1, ins, 32'h10, 32'h1234_5678, EXP_NONE);
        ins = enc_load(FUNCT3_LW_SW, 12'd0);
        ins[6:0] = 7'b0000111;
        add_row(1'b1, ins, 32'h10, '0, EXP_NONE);
        add_row(1'b1, enc_load(3'b011, 12'd0), 32'h10, '0, EXP_NONE);
        add_row(1'b0, enc_store(FUNCT3_LW_SW, 12'd0), 32'h04, 32'hCAFE_F00D, EXP_NONE);
        add_load(FUNCT3_LW_SW, 8'h10);
        add_load(FUNCT3_LW_SW, 8'h04);
    endtask

    // Writebacks checked in order and sampled mid-cycle
    always @(negedge clk_i) begin
        wb_exp_t e;
        logic    ok_val;
        logic    ok_lat;
        if (!reset_i) begin
            if (busy_o) begin
                busy_seen = 1'b1;
            end
            if (writeback_valid_o) begin
                if (expect_q.size() == 0) begin
                    fail_count++;
                    $display("Unexpected writeback at %0t with value %08h, no load pending",
                             $time, writeback_value_o);
                end else begin
                    e = expect_q.pop_front();
                    check_word(writeback_value_o, e.value,
                               $sformatf("row %0d writeback value", e.row), ok_val);
                    // Load data returns two cycles after the accepting cycle
                    check_flag(cycle_count == e.cycle + 2, 1'b1,
                               $sformatf("row %0d writeback latency", e.row), ok_lat);
                    $display("row %0d %s writeback %08h %s", e.row, op_name(rows[e.row].inst),
                             writeback_value_o, (ok_val && ok_lat) ? "ok" : "error");
                end
            end
        end
    end

    // Watchdog sized by the table
    initial begin
        int limit;
        wait (table_ready);
        limit = rows.size() * (DMEM_RD_LATENCY + 4) + 10;
        repeat (limit) @(posedge clk_i);
        $display("Timeout after %0d cycles, %0d writebacks never arrived",
                 limit, expect_q.size());
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        row_t       row;
        byte_addr_t addr;
        funct3_t    f3;
        wb_exp_t    e;
        logic       ok;
        reset_i = 1'b1;
        lsu_request_i = 1'b0;
        inst_i = '0;
        rs1_value_i = '0;
        rs2_value_i = '0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk_i);
        #5 reset_i = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            row = rows[i];
            @(posedge clk_i);
            #5;
            // Buffer is full exactly when that many loads still await writeback
            check_flag(busy_o, expect_q.size() == LSB_DEPTH,
                       $sformatf("row %0d busy_o", i), ok);
            // Hold off while the buffer is full
            while (busy_o) begin
                lsu_request_i = 1'b0;
                @(posedge clk_i);
                #5;
                check_flag(busy_o, expect_q.size() == LSB_DEPTH,
                           $sformatf("row %0d busy_o", i), ok);
            end
            lsu_request_i = row.req;
            inst_i = row.inst;
            rs1_value_i = row.rs1;
            rs2_value_i = row.rs2;
            addr = addr_of(row.inst, row.rs1);
            f3 = row.inst[14:12];
            if (row.req && row.kind == EXP_WB) begin
                e.value = load_model(addr, f3);
                e.row = 16'(i);
                e.cycle = cycle_count;
                expect_q.push_back(e);
            end
            if (row.req && row.kind == EXP_NONE && row.inst[6:0] == OP_STORE) begin
                store_model(addr, f3, row.rs2);
            end
            @(negedge clk_i);
            check_flag(misaligned_o, row.kind == EXP_MIS,
                       $sformatf("row %0d misaligned_o", i), ok);
            if (row.kind != EXP_WB) begin
                $display("row %0d %s addr %02h%s %s", i, op_name(row.inst), addr,
                         row.req ? "" : " idle", ok ? "ok" : "error");
            end
        end
        @(posedge clk_i);
        #5 lsu_request_i = 1'b0;
        while (expect_q.size() != 0) begin
            @(posedge clk_i);
        end
        // A few spare cycles to catch stray writebacks
        repeat (4) @(posedge clk_i);
        check_flag(busy_seen, 1'b1, "busy_o during load burst", ok);
        $display("busy during burst %s", ok ? "ok" : "error");
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hdl/rv_isa_pkg.sv
hdl/lsu_pkg.sv
hdl/lsu_ctrl.sv
hdl/lsu_load_buffer.sv
hdl/dmem.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
tb/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    --top-module lsu_tb \
    -Mdir obj_dir \
    -o lsu_sim \
    -f list.f

./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
